// File: common/isa_pkg.sv
/*
 * isa_pkg
 * instruction-set view of the front end: major opcodes and the
 * field layout of the direct jumps B and BL
 */
`default_nettype none

package isa_pkg;

	////////////////////////////////
	// instruction word

	localparam int INST_W = 32;		// fixed 32-bit encoding
	localparam int OPC_MSB = 31;	// major opcode, top six bits
	localparam int OPC_LSB = 26;
	localparam int OPC_W = OPC_MSB - OPC_LSB + 1;

	////////////////////////////////
	// B / BL offset fields

	// offs[15:0] in the middle of the word
	localparam int OFFS_LO_MSB = 25;
	localparam int OFFS_LO_LSB = 10;
	// offs[25:16] in the low bits
	localparam int OFFS_HI_MSB = 9;
	localparam int OFFS_HI_LSB = 0;

	// full offset, in words
	localparam int OFFS_W = (OFFS_HI_MSB - OFFS_HI_LSB + 1) + (OFFS_LO_MSB - OFFS_LO_LSB + 1);
	localparam int BR_SHIFT = 2;	// word offset to byte offset

	// major opcodes the front end tells apart
	typedef enum logic [OPC_W-1:0] {
		OP_OTHER = 6'h00,	// anything not pre-decoded
		OP_B     = 6'h14,	// direct jump
		OP_BL    = 6'h15	// direct jump and link
	} isa_opcode_t;

endpackage

`default_nettype wire

// File: common/fe_pkg.sv
/*
 * fe_pkg
 * sizes and constants of the fetch front end and its APB program port
 */
`default_nettype none

package fe_pkg;

	localparam int PC_W = 32;
	localparam logic [PC_W-1:0] RESET_PC = 32'h1c000000;	// first fetched word
	localparam logic [PC_W-1:0] PC_STEP = 32'd4;			// sequential step

	////////////////////////////////
	// instruction RAM

	localparam int MEM_WORDS = 1024;
	localparam int IDX_W = 10;
	localparam int IDX_LSB = 2;						// byte offset bits dropped
	localparam int IDX_MSB = IDX_LSB + IDX_W - 1;	// pc[11:2], aliases every 4 KiB

	////////////////////////////////
	// APB program port

	localparam int APB_AW = 32;
	localparam int APB_DW = 32;
	localparam logic [APB_AW-1:0] APB_LIMIT = 32'd4096;	// first byte address out of range

	// bus phase seen by the slave
	typedef enum logic [1:0] {
		APB_IDLE,	// psel low
		APB_SETUP,	// psel high, penable low
		APB_ACCESS	// transfer completes here
	} apb_state_t;

endpackage

`default_nettype wire

// File: common/fetch_if.sv
/*
 * fetch_if
 * one fetch slot handed from the fetch stage to pre-decode
 */
`timescale 1ns/100ps
`default_nettype none

interface fetch_if;

	logic							valid;		// slot holds a live pc
	logic							allow_in;	// pre-decode takes the slot
	logic [fe_pkg::PC_W-1:0]		pc;
	logic [isa_pkg::INST_W-1:0]	inst;		// RAM data for pc

	// fetch side
	modport fetch_src (
		output valid,
		output pc,
		input  allow_in
	);

	// pre-decode side
	modport fetch_dst (
		input  valid,
		input  pc,
		input  inst,
		output allow_in
	);

endinterface

`default_nettype wire

// File: fetch/if_stage.sv
/*
 * if_stage
 * keeps the pc, predicts not taken and reads the instruction RAM
 * with the next pc; a redirect from pre-decode drops the held slot
 */
`timescale 1ns/100ps
`default_nettype none

module if_stage (
	input  wire							clk,
	input  wire							reset,
	input  wire							run,			// allow new fetches
	input  wire							redirect,		// B/BL seen in pre-decode
	input  wire [fe_pkg::PC_W-1:0]		redirect_pc,
	output logic						ram_en,			// fetch read enable
	output logic [fe_pkg::IDX_W-1:0]	ram_addr,
	fetch_if.fetch_src					fe
);

	logic [fe_pkg::PC_W-1:0]	pc;
	logic [fe_pkg::PC_W-1:0]	pc_plus_4;
	logic [fe_pkg::PC_W-1:0]	pred_pc;
	logic [fe_pkg::PC_W-1:0]	next_pc;
	logic						valid;
	logic						allow_in;		// stage may advance
	logic						load;			// a new pc is fetched this cycle

	//////////////////////////////
	// slot control

	// empty slot, or the held one moves on
	assign allow_in = ~valid | fe.allow_in;
	assign load = run & (redirect | allow_in);

	always_ff @(posedge clk)
	begin
		if (reset)
			valid <= 1'b0;				// slot empty
		else if (redirect | allow_in)
			valid <= run;				// redirect kills the held slot
	end

	//////////////////////////////
	// pc

	assign pc_plus_4 = pc + fe_pkg::PC_STEP;
	assign pred_pc = pc_plus_4;			// static not-taken
	assign next_pc = redirect ? redirect_pc : pred_pc;

	always_ff @(posedge clk)
	begin
		if (reset)
			pc <= fe_pkg::RESET_PC - fe_pkg::PC_STEP;	// first next_pc is RESET_PC
		else if (load)
			pc <= next_pc;
		else if (redirect)
			pc <= redirect_pc - fe_pkg::PC_STEP;		// parked while run is low
	end

	//////////////////////////////
	// RAM read and slot out

	// read only on a pc load, so data holds through a stall
	assign ram_en = load;
	assign ram_addr = next_pc[fe_pkg::IDX_MSB:fe_pkg::IDX_LSB];

	assign fe.valid = valid;
	assign fe.pc = pc;

endmodule

`default_nettype wire

// File: fetch/ipd_stage.sv
/*
 * ipd_stage
 * latches each fetched word, spots the direct jumps B and BL and
 * redirects fetch to their target; feeds the decode handshake
 */
`timescale 1ns/100ps
`default_nettype none

module ipd_stage (
	input  wire								clk,
	input  wire								reset,
	input  wire								inst_ready,		// decode takes the word
	output logic							redirect,		// one cycle per jump
	output logic [fe_pkg::PC_W-1:0]			redirect_pc,
	output logic							inst_valid,
	output logic [fe_pkg::PC_W-1:0]			inst_pc,
	output logic [isa_pkg::INST_W-1:0]		inst_word,
	fetch_if.fetch_dst						fe
);

	localparam int EXT_W = fe_pkg::PC_W - isa_pkg::OFFS_W - isa_pkg::BR_SHIFT;

	logic							out_valid;
	logic							fresh;		// latched word not yet examined
	logic [fe_pkg::PC_W-1:0]		out_pc;
	logic [isa_pkg::INST_W-1:0]	out_word;
	logic							accept;		// slot moves in this cycle

	isa_pkg::isa_opcode_t			opcode;
	logic							is_jump;
	logic [isa_pkg::OFFS_W-1:0]	offs;		// word offset of B/BL
	logic [fe_pkg::PC_W-1:0]		offs_ext;	// sign extended, in bytes
	logic [fe_pkg::PC_W-1:0]		target;

	//////////////////////////////
	// handshake with fetch

	// empty or draining, and never while redirecting
	assign fe.allow_in = (~out_valid | inst_ready) & ~redirect;
	assign accept = fe.valid & fe.allow_in;

	always_ff @(posedge clk)
	begin
		if (reset)
			out_valid <= 1'b0;
		else if (accept)
			out_valid <= 1'b1;
		else if (inst_ready)
			out_valid <= 1'b0;		// word left, nothing new
	end

	// only the first cycle after a latch may redirect
	always_ff @(posedge clk)
	begin
		if (reset)
			fresh <= 1'b0;
		else
			fresh <= accept;
	end

	// payload
	always_ff @(posedge clk)
	begin
		if (accept)
		begin
			out_pc <= fe.pc;
			out_word <= fe.inst;
		end
	end

	//////////////////////////////
	// pre-decode

	always_comb
	begin
		case (out_word[isa_pkg::OPC_MSB:isa_pkg::OPC_LSB])
			isa_pkg::OP_B:  opcode = isa_pkg::OP_B;
			isa_pkg::OP_BL: opcode = isa_pkg::OP_BL;
			default:        opcode = isa_pkg::OP_OTHER;
		endcase
	end

	assign is_jump = (opcode == isa_pkg::OP_B) | (opcode == isa_pkg::OP_BL);

	// high part sits below the low part in the word
	assign offs = {out_word[isa_pkg::OFFS_HI_MSB:isa_pkg::OFFS_HI_LSB],
		out_word[isa_pkg::OFFS_LO_MSB:isa_pkg::OFFS_LO_LSB]};
	assign offs_ext = {{EXT_W{offs[isa_pkg::OFFS_W-1]}}, offs, {isa_pkg::BR_SHIFT{1'b0}}};
	assign target = out_pc + offs_ext;		// pc relative

	//////////////////////////////
	// outputs

	assign redirect = out_valid & fresh & is_jump;
	assign redirect_pc = target;

	assign inst_valid = out_valid;
	assign inst_pc = out_pc;
	assign inst_word = out_word;

endmodule

`default_nettype wire

// File: rtl/inst_ram.sv
/*
 * inst_ram
 * dual-port synchronous instruction memory: fetch reads on one port,
 * the APB program port reads and writes on the other
 */
`timescale 1ns/100ps
`default_nettype none

module inst_ram (
	input  wire								clk,
	// fetch port
	input  wire								rd_en,
	input  wire [fe_pkg::IDX_W-1:0]			rd_idx,
	output logic [isa_pkg::INST_W-1:0]		rd_data,
	// program port
	input  wire								pg_en,
	input  wire								pg_we,
	input  wire [fe_pkg::IDX_W-1:0]			pg_idx,
	input  wire [isa_pkg::INST_W-1:0]		pg_wdata,
	output logic [isa_pkg::INST_W-1:0]		pg_rdata
);

	logic [isa_pkg::INST_W-1:0] mem [fe_pkg::MEM_WORDS];

	//////////////////////////////
	// fetch port

	always_ff @(posedge clk)
	begin
		if (rd_en)
			rd_data <= mem[rd_idx];		// old word on a same-cycle write
	end

	//////////////////////////////
	// program port

	always_ff @(posedge clk)
	begin
		if (pg_en)
		begin
			if (pg_we)
				mem[pg_idx] <= pg_wdata;
			pg_rdata <= mem[pg_idx];		// read first
		end
	end

endmodule

`default_nettype wire

// File: rtl/apb_prog_port.sv
/*
 * apb_prog_port
 * APB slave, no wait states, that loads and reads back the program
 * through the program port of the instruction RAM
 */
`timescale 1ns/100ps
`default_nettype none

module apb_prog_port (
	input  wire								clk,
	input  wire								reset,
	input  wire								psel,
	input  wire								penable,
	input  wire								pwrite,
	input  wire [fe_pkg::APB_AW-1:0]		paddr,
	input  wire [fe_pkg::APB_DW-1:0]		pwdata,
	output logic [fe_pkg::APB_DW-1:0]		prdata,
	output logic							pready,
	output logic							pslverr,
	// RAM program port
	input  wire [isa_pkg::INST_W-1:0]		pg_rdata,
	output logic							pg_en,
	output logic							pg_we,
	output logic [fe_pkg::IDX_W-1:0]		pg_idx,
	output logic [isa_pkg::INST_W-1:0]		pg_wdata
);

	fe_pkg::apb_state_t	state;		// phase of the last cycle
	fe_pkg::apb_state_t	phase;		// phase of this cycle
	logic				in_range;
	logic				setup;
	logic				access;

	//////////////////////////////
	// phase tracking

	// access only straight after a setup
	always_comb
	begin
		phase = fe_pkg::APB_IDLE;
		if (psel)
			phase = (penable && state == fe_pkg::APB_SETUP) ? fe_pkg::APB_ACCESS
				: fe_pkg::APB_SETUP;
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			state <= fe_pkg::APB_IDLE;
		else
			state <= phase;
	end

	assign setup = (phase == fe_pkg::APB_SETUP);
	assign access = (phase == fe_pkg::APB_ACCESS);
	assign in_range = (paddr < fe_pkg::APB_LIMIT);

	//////////////////////////////
	// RAM program port

	// read in setup, data registered by access; write in access
	assign pg_en = in_range & ((setup & ~pwrite) | (access & pwrite));
	assign pg_we = access & pwrite;
	assign pg_idx = paddr[fe_pkg::IDX_MSB:fe_pkg::IDX_LSB];
	assign pg_wdata = pwdata;

	//////////////////////////////
	// bus response

	assign pready = access;					// never waits
	assign pslverr = access & ~in_range;
	assign prdata = (access & ~pwrite & in_range) ? pg_rdata : '0;

endmodule

`default_nettype wire

// File: rtl/fetch_frontend.sv
/*
 * fetch_frontend
 * instruction-fetch front end: fetch, pre-decode, instruction RAM and
 * the APB program port, giving an in-order (pc, instruction) stream
 */
`timescale 1ns/100ps
`default_nettype none

module fetch_frontend (
	input  wire								clk,
	input  wire								reset,
	input  wire								run,
	// decode side
	input  wire								inst_ready,
	output logic							inst_valid,
	output logic [fe_pkg::PC_W-1:0]			inst_pc,
	output logic [isa_pkg::INST_W-1:0]		inst_word,
	// APB program load
	input  wire								psel,
	input  wire								penable,
	input  wire								pwrite,
	input  wire [fe_pkg::APB_AW-1:0]		paddr,
	input  wire [fe_pkg::APB_DW-1:0]		pwdata,
	output logic [fe_pkg::APB_DW-1:0]		prdata,
	output logic							pready,
	output logic							pslverr
);

	logic							redirect;
	logic [fe_pkg::PC_W-1:0]		redirect_pc;
	logic							ram_en;
	logic [fe_pkg::IDX_W-1:0]		ram_addr;
	logic							pg_en;
	logic							pg_we;
	logic [fe_pkg::IDX_W-1:0]		pg_idx;
	logic [isa_pkg::INST_W-1:0]	pg_wdata;
	logic [isa_pkg::INST_W-1:0]	pg_rdata;

	fetch_if fe ();		// fetch to pre-decode slot

	if_stage u_if_stage (
		.clk         (clk),
		.reset       (reset),
		.run         (run),
		.redirect    (redirect),
		.redirect_pc (redirect_pc),
		.ram_en      (ram_en),
		.ram_addr    (ram_addr),
		.fe          (fe.fetch_src)
	);

	ipd_stage u_ipd_stage (
		.clk         (clk),
		.reset       (reset),
		.inst_ready  (inst_ready),
		.redirect    (redirect),
		.redirect_pc (redirect_pc),
		.inst_valid  (inst_valid),
		.inst_pc     (inst_pc),
		.inst_word   (inst_word),
		.fe          (fe.fetch_dst)
	);

	// fetch read data lands straight in the slot
	inst_ram u_inst_ram (
		.clk      (clk),
		.rd_en    (ram_en),
		.rd_idx   (ram_addr),
		.rd_data  (fe.inst),
		.pg_en    (pg_en),
		.pg_we    (pg_we),
		.pg_idx   (pg_idx),
		.pg_wdata (pg_wdata),
		.pg_rdata (pg_rdata)
	);

	apb_prog_port u_apb_prog_port (
		.clk      (clk),
		.reset    (reset),
		.psel     (psel),
		.penable  (penable),
		.pwrite   (pwrite),
		.paddr    (paddr),
		.pwdata   (pwdata),
		.prdata   (prdata),
		.pready   (pready),
		.pslverr  (pslverr),
		.pg_rdata (pg_rdata),
		.pg_en    (pg_en),
		.pg_we    (pg_we),
		.pg_idx   (pg_idx),
		.pg_wdata (pg_wdata)
	);

endmodule

`default_nettype wire

// File: testbench/tb_fetch_frontend.sv
/*
 * tb_fetch_frontend
 * loads random programs over APB, then checks the fetched
 * (pc, instruction) stream against a walk through a copy of the program
 */
`timescale 1ns/100ps
`default_nettype none

module tb_fetch_frontend;

	localparam int WORDS = 1024;		// program size in words
	localparam int SEQ_WORDS = 1100;	// runs past the 4 KiB wrap
	localparam int BR_WORDS = 400;
	localparam int LOADED = 2 * WORDS;
	localparam int CHECKED = 2 * WORDS + SEQ_WORDS + 3 * BR_WORDS;
	localparam int CYCLE_LIMIT = 8 * (LOADED + CHECKED) + 200;

	logic			clk;
	logic			reset;
	logic			run;
	logic			inst_ready;
	logic			inst_valid;
	logic [31:0]	inst_pc;
	logic [31:0]	inst_word;
	logic			psel;
	logic			penable;
	logic			pwrite;
	logic [31:0]	paddr;
	logic [31:0]	pwdata;
	logic [31:0]	prdata;
	logic			pready;
	logic			pslverr;

	logic [31:0]	prog [WORDS];	// copy of the RAM
	logic [31:0]	model_pc;		// next pc the walk expects
	bit				held;			// last word offered but not taken
	logic [31:0]	held_pc;
	logic [31:0]	held_word;
	int				cycles = 0;

	fetch_frontend u_fetch_frontend (
		.clk        (clk),
		.reset      (reset),
		.run        (run),
		.inst_ready (inst_ready),
		.inst_valid (inst_valid),
		.inst_pc    (inst_pc),
		.inst_word  (inst_word),
		.psel       (psel),
		.penable    (penable),
		.pwrite     (pwrite),
		.paddr      (paddr),
		.pwdata     (pwdata),
		.prdata     (prdata),
		.pready     (pready),
		.pslverr    (pslverr)
	);

	initial
	begin
		clk = 1'b0;
		forever #2 clk = ~clk;	// 4 ns period
	end

	always @(posedge clk)
	begin
		cycles = cycles + 1;
		if (cycles >= CYCLE_LIMIT)
		begin
			$display("timeout: the run went past %0d cycles", CYCLE_LIMIT);
			$display("RESULT: FAIL");
			$fatal(1, "timeout");
		end
	end

	//////////////////////////////
	// checking and model

	task automatic check_equal(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		if (got !== exp)
		begin
			$display("[FAIL] t=%0t %s: got %h, expected %h", $time, name, got, exp);
			$display("RESULT: FAIL");
			$fatal(1, "mismatch on %s", name);
		end
	endtask

	// random word, opcode kept off B/BL unless a jump is wanted
	function automatic logic [31:0] rand_word(input bit branches);
		logic [31:0] w;
		w = $urandom;
		if (branches && ($urandom % 8 == 0))
			w[31:26] = ($urandom % 2) ? isa_pkg::OP_BL : isa_pkg::OP_B;
		else if (w[31:26] == isa_pkg::OP_B || w[31:26] == isa_pkg::OP_BL)
			w[31:26] = isa_pkg::OP_OTHER;
		return w;					// low 26 bits are a random offset
	endfunction

	// jump target, else the next word
	function automatic logic [31:0] walk_next(input logic [31:0] pc, input logic [31:0] w);
		isa_pkg::isa_opcode_t opc;
		logic [25:0] offs;
		opc = isa_pkg::isa_opcode_t'(w[31:26]);
		offs = {w[9:0], w[25:10]};	// high part sits in the low bits
		if (opc == isa_pkg::OP_B || opc == isa_pkg::OP_BL)
			return pc + {{4{offs[25]}}, offs, 2'b00};
		return pc + 32'd4;
	endfunction

	//////////////////////////////
	// APB driver

	// setup then access, next transfer may follow straight on
	task automatic apb_access(input logic wr, input logic [31:0] addr,
			input logic [31:0] wdata, output logic [31:0] rdata, output logic err);
		@(negedge clk);
		psel = 1'b1;
		penable = 1'b0;
		pwrite = wr;
		paddr = addr;
		pwdata = wdata;
		@(negedge clk);
		penable = 1'b1;
		#1;
		check_equal("pready", pready, 1);	// no wait states
		rdata = prdata;
		err = pslverr;
	endtask

	task automatic apb_idle;
		@(negedge clk);
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
	endtask

	task automatic load_program(input bit branches);
		logic [31:0] rdata;
		logic err;
		for (int i = 0; i < WORDS; i++)
		begin
			prog[i] = rand_word(branches);
			apb_access(1'b1, i * 4, prog[i], rdata, err);
			check_equal("pslverr", err, 0);
		end
		for (int i = 0; i < WORDS; i++)
		begin
			apb_access(1'b0, i * 4, 32'h0, rdata, err);
			check_equal("pslverr", err, 0);
			check_equal("prdata", rdata, prog[i]);
		end
		apb_idle;
	endtask

	// writes above 4 KiB must not touch the aliased word
	task automatic out_of_range;
		logic [31:0] addr;
		logic [31:0] rdata;
		logic err;
		for (int k = 0; k < 8; k++)
		begin
			addr = (k == 0) ? 32'h1000 : (($urandom | 32'h1000) & ~32'h3);
			apb_access(1'b1, addr, $urandom, rdata, err);
			check_equal("pslverr", err, 1);
			apb_access(1'b0, addr, 32'h0, rdata, err);
			check_equal("pslverr", err, 1);
			check_equal("prdata", rdata, 0);
			apb_access(1'b0, addr & 32'hffc, 32'h0, rdata, err);
			check_equal("pslverr", err, 0);
			check_equal("prdata", rdata, prog[addr[11:2]]);
		end
		apb_idle;
	endtask

	//////////////////////////////
	// fetch stream

	task automatic apply_reset;
		@(negedge clk);
		reset = 1'b1;
		run = 1'b0;
		inst_ready = 1'b0;
		repeat (5) @(negedge clk);
		reset = 1'b0;
		model_pc = fe_pkg::RESET_PC;
		held = 1'b0;
		#1;
		check_equal("inst_valid", inst_valid, 0);
		check_equal("pslverr", pslverr, 0);
		check_equal("redirect", u_fetch_frontend.redirect, 0);
		check_equal("fetch slot valid", u_fetch_frontend.fe.valid, 0);
	endtask

	// one cycle seen mid low phase, well away from the edge
	task automatic observe(output bit took);
		took = 1'b0;
		#1;
		if (held)
		begin
			check_equal("inst_valid held", inst_valid, 1);
			check_equal("inst_pc held", inst_pc, held_pc);
			check_equal("inst_word held", inst_word, held_word);
		end
		if (inst_valid && inst_ready)
		begin
			check_equal("inst_pc", inst_pc, model_pc);
			check_equal("inst_word", inst_word, prog[model_pc[11:2]]);
			model_pc = walk_next(model_pc, prog[model_pc[11:2]]);
			took = 1'b1;
		end
		held = inst_valid & ~inst_ready;
		held_pc = inst_pc;
		held_word = inst_word;
	endtask

	task automatic stream(input int n, input bit ready_rand, input bit run_rand,
			input bit gapless);
		int got;
		bit took;
		got = 0;
		while (got < n)
		begin
			@(negedge clk);
			inst_ready = ready_rand ? 1'($urandom % 2) : 1'b1;
			if (!run_rand)
				run = 1'b1;
			else if ($urandom % 4 == 0)
				run = ~run;			// pause or resume fetch
			observe(took);
			if (gapless && got > 0)
				check_equal("inst_valid", inst_valid, 1);	// one word per cycle
			got = got + took;
		end
	endtask

	// run low, in-flight words leave, then nothing more
	task automatic drain;
		bit took;
		for (int c = 0; c < 24; c++)
		begin
			@(negedge clk);
			run = 1'b0;
			inst_ready = 1'b1;
			observe(took);
			if (c >= 8)
				check_equal("inst_valid", inst_valid, 0);
		end
	endtask

	//////////////////////////////
	// test sequence

	initial
	begin
		reset = 1'b1;
		run = 1'b0;
		inst_ready = 1'b0;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = 32'h0;
		pwdata = 32'h0;
		held = 1'b0;
		void'($urandom(32'h5c5b));

		apply_reset;
		load_program(1'b0);				// no jumps
		out_of_range;
		stream(SEQ_WORDS, 1'b0, 1'b0, 1'b1);

		apply_reset;
		load_program(1'b1);				// about one jump in eight
		apply_reset;
		stream(BR_WORDS, 1'b0, 1'b0, 1'b0);
		apply_reset;
		stream(BR_WORDS, 1'b1, 1'b0, 1'b0);	// back-pressure
		apply_reset;
		stream(BR_WORDS, 1'b1, 1'b1, 1'b0);	// run toggling
		drain;

		$display("RESULT: PASS");
		$finish;
	end

endmodule

`default_nettype wire

// File: compile.f
common/isa_pkg.sv
common/fe_pkg.sv
common/fetch_if.sv
fetch/if_stage.sv
fetch/ipd_stage.sv
rtl/inst_ram.sv
rtl/apb_prog_port.sv
rtl/fetch_frontend.sv
testbench/tb_fetch_frontend.sv
